// File: hw/st_link_pkg.sv
// Streaming link shared types

package st_link_pkg;

  ////////////////////////////////////////
  // Link item and PHY word

  // One AXI-stream beat as carried over the link
  typedef struct packed {
    logic        tlast;
    logic [7:0]  tkeep;
    logic [63:0] tdata;
  } st_item_t;

  // Raw PHY transfer, one per clock
  typedef logic [79:0] phy_word_t;

  ////////////////////////////////////////
  // Counts and delays

  // Transmit credit count
  typedef logic [7:0] credit_t;

  // Delay in clk_wr cycles
  typedef logic [15:0] delay_t;

  // Transmit debug status word, 32 bits
  typedef struct packed {
    logic [15:0] push_count;
    logic [6:0]  reserved;
    logic        online;
    credit_t     credit;
  } tx_debug_t;

  ////////////////////////////////////////
  // PHY bit positions

  // Outgoing word
  localparam int PHY_PUSH_BIT = 0;
  localparam int PHY_STB_BIT = 1;
  // Link item sits in bits 2 to 74
  localparam int PHY_DATA_LSB = 2;
  localparam int PHY_MRK_BIT = 79;

  // Incoming word, credit return
  localparam int PHY_CREDIT_BIT = 0;

endpackage

// File: hw/ll_auto_sync.sv
// Link startup sequencer

`timescale 1ns/100ps

module ll_auto_sync import st_link_pkg::*; #(
  parameter int MARKER_WIDTH = 1,
  parameter bit PERSISTENT_MARKER = 1'b0,
  parameter bit PERSISTENT_STROBE = 1'b0
) (
  input  logic                    clk_wr,
  input  logic                    reset,
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  delay_t                  delay_x_value,
  input  delay_t                  delay_y_value,
  input  delay_t                  delay_z_value,
  input  logic [MARKER_WIDTH-1:0] tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  output logic                    tx_online_delay,
  output logic                    rx_online_delay,
  output logic [MARKER_WIDTH-1:0] tx_auto_mrk_userbit,
  output logic                    tx_auto_stb_userbit
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_ONLINE,
    WAIT_SYNC,
    SYNCED
  } sync_state_t;

  ////////////////////////////////////////
  // Online delay

  // Index 0 is tx, index 1 is rx
  logic   online_in [2];
  delay_t online_limit [2];
  delay_t online_cnt [2];
  logic   online_dly [2];

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign online_limit[0] = delay_x_value;
  assign online_limit[1] = delay_z_value;

  for (genvar i = 0; i < 2; i++) begin : g_online
    // Counter saturates at the limit, level rises there
    always_ff @(posedge clk_wr) begin
      if (reset) begin
        online_cnt[i] <= '0;
        online_dly[i] <= 1'b0;
      end else if (!online_in[i]) begin
        // Drop straight away once the raw level goes low
        online_cnt[i] <= '0;
        online_dly[i] <= 1'b0;
      end else if (online_cnt[i] == online_limit[i]) begin
        online_dly[i] <= 1'b1;
      end else begin
        online_cnt[i] <= online_cnt[i] + 1'b1;
      end
    end
  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

  ////////////////////////////////////////
  // Sync strobe and marker

  sync_state_t state;
  delay_t      sync_cnt;
  logic        sync_hit;
  logic        stb_pulse;
  logic        mrk_pulse;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state    <= IDLE;
      sync_cnt <= '0;
    end else if (!tx_online) begin
      state    <= IDLE;
      sync_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          state <= WAIT_ONLINE;
        end
        WAIT_ONLINE: begin
          // Count starts on the first clock after the delayed level rises
          if (tx_online_delay) begin
            state    <= WAIT_SYNC;
            sync_cnt <= delay_t'(1);
          end
        end
        WAIT_SYNC, SYNCED: begin
          // Restart the period on each hit
          if (sync_hit) begin
            state    <= SYNCED;
            sync_cnt <= delay_t'(1);
          end else if (sync_cnt != '1) begin
            sync_cnt <= sync_cnt + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign sync_hit = ((state == WAIT_SYNC) || (state == SYNCED)) &&
                    (sync_cnt >= delay_y_value);

  // First hit always fires, later hits only when persistent
  assign stb_pulse = sync_hit && ((state == WAIT_SYNC) || PERSISTENT_STROBE);
  assign mrk_pulse = sync_hit && ((state == WAIT_SYNC) || PERSISTENT_MARKER);

  // User bits pass through alongside the generated pulses
  assign tx_auto_stb_userbit = stb_pulse | tx_stb_userbit;
  assign tx_auto_mrk_userbit = {MARKER_WIDTH{mrk_pulse}} | tx_mrk_userbit;

endmodule

// File: hw/st_user_pack.sv
// AXI-stream beat packer

`timescale 1ns/100ps

module st_user_pack import st_link_pkg::*; (
  input  logic        clk_wr,
  input  logic        reset,
  input  logic [7:0]  user_tkeep,
  input  logic [63:0] user_tdata,
  input  logic        user_tlast,
  input  logic        user_tvalid,
  input  logic        item_ready,
  output logic        user_tready,
  output logic        item_valid,
  output st_item_t    item
);

  st_item_t beat_item;
  st_item_t hold_item;
  logic     hold_valid;
  logic     beat_accept;

  ////////////////////////////////////////
  // Beat packing

  always_comb begin
    beat_item.tlast = user_tlast;
    beat_item.tkeep = user_tkeep;
    beat_item.tdata = user_tdata;
  end

  // Room when empty, or when the held item leaves this clock
  assign user_tready = !hold_valid || item_ready;
  assign beat_accept = user_tvalid && user_tready;

  ////////////////////////////////////////
  // One-entry holding register

  // Valid flag
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (beat_accept) begin
      hold_valid <= 1'b1;
    end else if (item_ready) begin
      // Held item is pushed, nothing new behind it
      hold_valid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_wr) begin
    if (beat_accept) begin
      hold_item <= beat_item;
    end
  end

  assign item_valid = hold_valid;
  assign item       = hold_item;

endmodule

// File: hw/ll_transmit.sv
// Link transmit credit control

`timescale 1ns/100ps

module ll_transmit import st_link_pkg::*; #(
  parameter credit_t DEFAULT_TX_CRED = 8'd128
) (
  input  logic      clk_wr,
  input  logic      reset,
  input  logic      tx_online,
  input  logic      rx_online,
  input  credit_t   init_credit,
  input  logic      item_valid,
  input  st_item_t  item,
  input  logic      credit_return,
  output logic      item_ready,
  output logic      push,
  output st_item_t  push_item,
  output tx_debug_t debug_status
);

  logic        online;
  credit_t     start_credit;
  credit_t     credit_cnt;
  logic [15:0] push_count;

  ////////////////////////////////////////
  // Credit counter

  // Both directions must be up
  assign online = tx_online && rx_online;

  // Zero init credit selects the built-in default
  assign start_credit = (init_credit == '0) ? DEFAULT_TX_CRED : init_credit;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_cnt <= '0;
    end else if (!online) begin
      // Reload while the link is down
      credit_cnt <= start_credit;
    end else begin
      case ({push, credit_return})
        2'b10: begin
          credit_cnt <= credit_cnt - 1'b1;
        end
        2'b01: begin
          // Saturate rather than wrap
          if (credit_cnt != '1) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        default: begin
          // Push and return together cancel
          credit_cnt <= credit_cnt;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Push decision

  // No dependence on item_valid here
  assign item_ready = online && (credit_cnt != '0);
  assign push       = item_valid && item_ready;
  assign push_item  = item;

  ////////////////////////////////////////
  // Debug status

  // Push counter, wraps
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      push_count <= '0;
    end else if (push) begin
      push_count <= push_count + 1'b1;
    end
  end

  always_comb begin
    debug_status.push_count = push_count;
    debug_status.reserved   = '0;
    debug_status.online     = online;
    debug_status.credit     = credit_cnt;
  end

endmodule

// File: hw/phy_concat.sv
// PHY word assembly

`timescale 1ns/100ps

module phy_concat import st_link_pkg::*; (
  input  logic      clk_wr,
  input  logic      reset,
  input  logic      push,
  input  st_item_t  push_item,
  input  logic      stb_bit,
  input  logic      mrk_bit,
  input  phy_word_t rx_phy0,
  output phy_word_t tx_phy0,
  output logic      credit_return
);

  phy_word_t next_word;

  ////////////////////////////////////////
  // Outgoing word

  always_comb begin
    // Unused bits 75 to 78 stay zero
    next_word = '0;
    next_word[PHY_PUSH_BIT] = push;
    next_word[PHY_STB_BIT]  = stb_bit;
    next_word[PHY_MRK_BIT]  = mrk_bit;
    // Data field only carries an item on a push
    if (push) begin
      next_word[PHY_DATA_LSB +: $bits(st_item_t)] = push_item;
    end
  end

  // Whole word reset so the link idles clean
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= next_word;
    end
  end

  ////////////////////////////////////////
  // Credit return

  // Each clock with the bit set is one credit
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= rx_phy0[PHY_CREDIT_BIT];
    end
  end

endmodule

// File: hw/axi_st_d64_master_top.sv
// AXI-stream 64-bit link transmitter

`timescale 1ns/100ps

module axi_st_d64_master_top import st_link_pkg::*; #(
  parameter bit      PERSISTENT_STROBE = 1'b0,
  parameter credit_t DEFAULT_TX_CRED = 8'd128
) (
  input  logic        clk_wr,
  input  logic        reset,

  // Online and sync control
  input  logic        tx_online,
  input  logic        rx_online,
  input  credit_t     init_st_credit,
  input  logic        tx_mrk_userbit,
  input  logic        tx_stb_userbit,

  // Startup delays
  input  delay_t      delay_x_value,
  input  delay_t      delay_y_value,
  input  delay_t      delay_z_value,

  // PHY
  output phy_word_t   tx_phy0,
  input  phy_word_t   rx_phy0,

  // Stream channel
  input  logic [7:0]  user_tkeep,
  input  logic [63:0] user_tdata,
  input  logic        user_tlast,
  input  logic        user_tvalid,
  output logic        user_tready,

  // Debug
  output tx_debug_t   tx_st_debug_status
);

  ////////////////////////////////////////
  // Interconnect

  logic     tx_online_delay;
  logic     rx_online_delay;
  logic     auto_stb;
  logic     auto_mrk;
  logic     item_valid;
  logic     item_ready;
  st_item_t item;
  logic     push;
  st_item_t push_item;
  logic     credit_return;

  ////////////////////////////////////////
  // Startup sequencer

  // Single marker bit, marker fires once
  ll_auto_sync #(
    .MARKER_WIDTH      (1),
    .PERSISTENT_MARKER (1'b0),
    .PERSISTENT_STROBE (PERSISTENT_STROBE)
  ) ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .reset               (reset),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (auto_mrk),
    .tx_auto_stb_userbit (auto_stb)
  );

  // User beat into link item
  st_user_pack st_user_pack_i (
    .clk_wr      (clk_wr),
    .reset       (reset),
    .user_tkeep  (user_tkeep),
    .user_tdata  (user_tdata),
    .user_tlast  (user_tlast),
    .user_tvalid (user_tvalid),
    .item_ready  (item_ready),
    .user_tready (user_tready),
    .item_valid  (item_valid),
    .item        (item)
  );

  // Credit and push
  ll_transmit #(
    .DEFAULT_TX_CRED (DEFAULT_TX_CRED)
  ) ll_transmit_i (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .tx_online     (tx_online_delay),
    .rx_online     (rx_online_delay),
    .init_credit   (init_st_credit),
    .item_valid    (item_valid),
    .item          (item),
    .credit_return (credit_return),
    .item_ready    (item_ready),
    .push          (push),
    .push_item     (push_item),
    .debug_status  (tx_st_debug_status)
  );

  ////////////////////////////////////////
  // PHY side

  phy_concat phy_concat_i (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .push          (push),
    .push_item     (push_item),
    .stb_bit       (auto_stb),
    .mrk_bit       (auto_mrk),
    .rx_phy0       (rx_phy0),
    .tx_phy0       (tx_phy0),
    .credit_return (credit_return)
  );

endmodule

// File: bench/tb_link_partner.sv
// Link partner model

`timescale 1ns/100ps

module tb_link_partner import st_link_pkg::*; (
  input  logic      clk_wr,
  input  logic      reset,
  input  logic      credit_enable,
  input  logic      credit_coin,
  input  phy_word_t tx_phy0,
  output phy_word_t rx_phy0,
  output logic      item_seen,
  output st_item_t  item,
  output int        items_received,
  output int        credit_pulses
);

  logic credit_due;
  logic credit_bit = 1'b0;

  ////////////////////////////////////////
  // Receive side

  // A pushed word carries one item
  assign item_seen = tx_phy0[PHY_PUSH_BIT];
  assign item      = tx_phy0[PHY_DATA_LSB +: $bits(st_item_t)];

  always @(posedge clk_wr) begin
    if (reset) begin
      items_received <= 0;
    end else if (item_seen) begin
      items_received <= items_received + 1;
    end
  end

  ////////////////////////////////////////
  // Credit return

  // Credit only for items already taken in
  always @(posedge clk_wr) begin
    if (reset) begin
      credit_due <= 1'b0;
    end else begin
      credit_due <= credit_enable && credit_coin && (items_received > credit_pulses);
    end
  end

  // Pulse goes out on the falling edge
  always @(negedge clk_wr) begin
    if (reset) begin
      credit_bit    <= 1'b0;
      credit_pulses <= 0;
    end else begin
      credit_bit <= credit_due;
      if (credit_due) begin
        credit_pulses <= credit_pulses + 1;
      end
    end
  end

  always_comb begin
    rx_phy0 = '0;
    rx_phy0[PHY_CREDIT_BIT] = credit_bit;
  end

endmodule

// File: bench/tb_axi_st_d64_master.sv
// Link transmitter testbench

`timescale 1ns/100ps

module tb_axi_st_d64_master import st_link_pkg::*; ();

  localparam int      TIMEOUT     = 400;
  localparam credit_t INIT_CREDIT = 8'd5;
  localparam delay_t  DELAY_X     = 16'd12;
  localparam delay_t  DELAY_Y     = 16'd6;
  localparam delay_t  DELAY_Z     = 16'd20;
  // Earliest tx_online count at which the sync bits may show
  localparam int      SYNC_EARLY  = DELAY_X + DELAY_Y;
  localparam int      DATA_MSB    = PHY_DATA_LSB + $bits(st_item_t) - 1;

  logic        clk_wr;
  logic        reset;
  logic        tx_online;
  logic        rx_online;
  logic        user_tvalid;
  logic        user_tlast;
  logic [7:0]  user_tkeep;
  logic [63:0] user_tdata;
  logic        user_tready;
  phy_word_t   tx_phy0;
  phy_word_t   rx_phy0;
  tx_debug_t   tx_st_debug_status;
  logic        credit_enable;
  logic        credit_coin;
  logic        item_seen;
  st_item_t    rx_item;
  int          items_received;
  int          credit_pulses;

  // Scoreboard and monitor state
  st_item_t    expected[$];
  st_item_t    exp_item;
  logic [31:0] stim_lfsr = 32'hb3f6;
  logic [31:0] credit_lfsr = 32'hb3f6;
  int          tx_high;
  int          rx_high;
  int          pushes_seen;
  int          stb_seen;
  int          mrk_seen;
  logic        ret_d1;
  int          ret_applied;

  axi_st_d64_master_top #(
    .PERSISTENT_STROBE (1'b0)
  ) dut (
    .*,
    .init_st_credit (INIT_CREDIT),
    .tx_mrk_userbit (1'b0),
    .tx_stb_userbit (1'b0),
    .delay_x_value  (DELAY_X),
    .delay_y_value  (DELAY_Y),
    .delay_z_value  (DELAY_Z)
  );

  tb_link_partner partner (
    .clk_wr, .reset, .credit_enable, .credit_coin, .tx_phy0, .rx_phy0,
    .item_seen, .item (rx_item), .items_received, .credit_pulses
  );

  initial begin
    clk_wr = 1'b0;
    forever #50 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Helpers

  task automatic end_failed();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic note_mismatch(input string name, input logic [79:0] got,
                               input logic [79:0] want);
    $display("CHECK FAILED %s: got %h expected %h", name, got, want);
    end_failed();
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    end_failed();
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One step per bit drawn
  function automatic logic [63:0] take_bits(input int count);
    logic [63:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      bits = {bits[62:0], stim_lfsr[0]};
    end
    return bits;
  endfunction

  // Random gap, then hold the beat until accepted
  task automatic send_beat();
    logic [63:0] gap;
    logic        accepted;
    int          waited;
    gap = take_bits(2);
    user_tvalid = 1'b0;
    repeat (int'(gap)) @(negedge clk_wr);
    user_tdata  = take_bits(64);
    user_tkeep  = 8'(take_bits(8));
    user_tlast  = take_bits(1) != 0;
    user_tvalid = 1'b1;
    accepted = 1'b0;
    waited = 0;
    while (!accepted) begin
      @(posedge clk_wr);
      accepted = user_tready;
      waited++;
      if (waited > TIMEOUT)
        abort_run("user_tready stayed low while a beat was offered");
    end
    @(negedge clk_wr);
    user_tvalid = 1'b0;
  endtask

  ////////////////////////////////////////
  // Monitors

  always @(negedge clk_wr) begin
    credit_lfsr = lfsr_step(credit_lfsr);
    credit_coin <= credit_lfsr[0];
  end

  // Online time, PHY bits seen, credit as the counter applies it
  always @(posedge clk_wr) begin
    if (reset) begin
      tx_high     <= 0;
      rx_high     <= 0;
      pushes_seen <= 0;
      stb_seen    <= 0;
      mrk_seen    <= 0;
      ret_d1      <= 1'b0;
      ret_applied <= 0;
    end else begin
      if (tx_online)
        tx_high <= tx_high + 1;
      if (rx_online)
        rx_high <= rx_high + 1;
      if (tx_phy0[PHY_PUSH_BIT])
        pushes_seen <= pushes_seen + 1;
      if (tx_phy0[PHY_STB_BIT])
        stb_seen <= stb_seen + 1;
      if (tx_phy0[PHY_MRK_BIT])
        mrk_seen <= mrk_seen + 1;
      // Registered return, then one more clock into the count
      ret_d1 <= rx_phy0[PHY_CREDIT_BIT];
      if (ret_d1)
        ret_applied <= ret_applied + 1;
    end
  end

  // Scoreboard of accepted beats in order
  always @(posedge clk_wr) begin
    if (!reset) begin
      if (item_seen) begin
        if (expected.size() == 0) begin
          abort_run("item on tx_phy0 with no accepted beat left");
        end else begin
          exp_item = expected.pop_front();
          assert (rx_item == exp_item)
            else note_mismatch("tx_phy0 item", rx_item, exp_item);
        end
      end
      if (user_tvalid && user_tready)
        expected.push_back({user_tlast, user_tkeep, user_tdata});
    end
  end

  ////////////////////////////////////////
  // Assertions

  // No push before both delays
  assert property (@(posedge clk_wr) disable iff (reset)
    !tx_phy0[PHY_PUSH_BIT] || (tx_high > DELAY_X && rx_high > DELAY_Z))
    else abort_run("push bit on tx_phy0 before both online delays ran out");

  // One-shot strobe and marker
  assert property (@(posedge clk_wr) disable iff (reset)
    !tx_phy0[PHY_STB_BIT] || stb_seen == 0)
    else note_mismatch("strobe count", $sampled(stb_seen) + 1, 1);
  assert property (@(posedge clk_wr) disable iff (reset)
    !tx_phy0[PHY_MRK_BIT] || mrk_seen == 0)
    else note_mismatch("marker count", $sampled(mrk_seen) + 1, 1);
  assert property (@(posedge clk_wr) disable iff (reset)
    !(tx_phy0[PHY_STB_BIT] || tx_phy0[PHY_MRK_BIT]) ||
    (tx_high >= SYNC_EARLY && tx_high <= SYNC_EARLY + 3))
    else abort_run("strobe or marker bit outside its startup window");

  // Spare bits zero, data field zero when idle
  assert property (@(posedge clk_wr) disable iff (reset)
    tx_phy0[PHY_MRK_BIT-1:DATA_MSB+1] == '0 &&
    (tx_phy0[PHY_PUSH_BIT] || tx_phy0[DATA_MSB:PHY_DATA_LSB] == '0))
    else note_mismatch("tx_phy0", $sampled(tx_phy0), '0);

  // Debug count includes the push now on tx_phy0
  assert property (@(posedge clk_wr) disable iff (reset)
    tx_st_debug_status.push_count == 16'(pushes_seen + tx_phy0[PHY_PUSH_BIT]))
    else note_mismatch("tx_st_debug_status.push_count",
                       $sampled(tx_st_debug_status.push_count),
                       $sampled(pushes_seen) + $sampled(tx_phy0[PHY_PUSH_BIT]));

  // Credit is init plus returns minus pushes
  assert property (@(posedge clk_wr) disable iff (reset)
    !tx_st_debug_status.online ||
    int'(tx_st_debug_status.credit) ==
    int'(INIT_CREDIT) + ret_applied - pushes_seen - int'(tx_phy0[PHY_PUSH_BIT]))
    else note_mismatch("tx_st_debug_status.credit",
                       $sampled(tx_st_debug_status.credit),
                       int'(INIT_CREDIT) + $sampled(ret_applied) - $sampled(pushes_seen) -
                       int'($sampled(tx_phy0[PHY_PUSH_BIT])));

  ////////////////////////////////////////
  // Stimulus

  initial begin
    int waited;
    reset         = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    user_tvalid   = 1'b0;
    user_tlast    = 1'b0;
    user_tkeep    = '0;
    user_tdata    = '0;
    credit_enable = 1'b0;
    credit_coin   = 1'b0;
    repeat (8) @(negedge clk_wr);
    reset = 1'b0;

    // Idle state out of reset
    assert (tx_phy0 == '0) else note_mismatch("tx_phy0", tx_phy0, '0);
    assert (tx_st_debug_status.push_count == '0)
      else note_mismatch("push_count", tx_st_debug_status.push_count, 0);
    assert (!tx_st_debug_status.online)
      else note_mismatch("online", tx_st_debug_status.online, 0);
    assert (user_tready) else note_mismatch("user_tready", user_tready, 1);

    // Beats offered before the link is up
    tx_online = 1'b1;
    rx_online = 1'b1;
    repeat (6) send_beat();

    // Init credit only and no returns
    waited = 0;
    while (pushes_seen < int'(INIT_CREDIT)) begin
      @(negedge clk_wr);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for the init credit pushes");
    end
    repeat (40) begin
      @(negedge clk_wr);
      assert (pushes_seen == int'(INIT_CREDIT))
        else note_mismatch("push count", pushes_seen, INIT_CREDIT);
      assert (!user_tready) else note_mismatch("user_tready", user_tready, 0);
    end

    // Partner returns credit from here on
    credit_enable = 1'b1;
    repeat (60) send_beat();
    waited = 0;
    while (expected.size() != 0) begin
      @(negedge clk_wr);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for accepted beats on tx_phy0");
    end
    waited = 0;
    while (credit_pulses != items_received) begin
      @(negedge clk_wr);
      waited++;
      if (waited > TIMEOUT)
        abort_run("timed out waiting for the partner to return credit");
    end
    repeat (4) @(negedge clk_wr);

    // Final state
    assert (stb_seen == 1) else note_mismatch("strobe count", stb_seen, 1);
    assert (mrk_seen == 1) else note_mismatch("marker count", mrk_seen, 1);
    assert (tx_st_debug_status.online)
      else note_mismatch("online", tx_st_debug_status.online, 1);
    assert (tx_st_debug_status.push_count == 16'(pushes_seen))
      else note_mismatch("push_count", tx_st_debug_status.push_count, pushes_seen);
    assert (tx_st_debug_status.credit == INIT_CREDIT)
      else note_mismatch("credit", tx_st_debug_status.credit, INIT_CREDIT);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: project.f
hw/st_link_pkg.sv
hw/ll_auto_sync.sv
hw/st_user_pack.sv
hw/ll_transmit.sv
hw/phy_concat.sv
hw/axi_st_d64_master_top.sv
bench/tb_link_partner.sv
bench/tb_axi_st_d64_master.sv
